// File: Bender.yml
package:
  name: smc

sources:
  # Packages first, then the blocks and the top
  - files:
      - rtl/smc_bus_pkg.sv
      - rtl/smc_mem_pkg.sv
      - rtl/smc_apb_regs.sv
      - rtl/smc_ahb_slave.sv
      - rtl/smc_emi_fsm.sv
      - rtl/smc_top.sv
  - target: simulation
    files:
      - tb/smc_sram_model.sv
      - tb/smc_assert.sv
      - tb/smc_tb.sv

// File: list.f
rtl/smc_bus_pkg.sv
rtl/smc_mem_pkg.sv
rtl/smc_apb_regs.sv
rtl/smc_ahb_slave.sv
rtl/smc_emi_fsm.sv
rtl/smc_top.sv
tb/smc_sram_model.sv
tb/smc_assert.sv
tb/smc_tb.sv

// File: rtl/smc_ahb_slave.sv
// --------------------
// SMC AHB-lite slave
// --------------------

module smc_ahb_slave #(
  parameter int ADDR_BITS = 16
) (
  input  logic                 hclk,
  input  logic                 reset,
  input  logic                 hsel,
  input  logic [31:0]          haddr,
  input  logic [1:0]           htrans,
  input  logic                 hwrite,
  input  logic [2:0]           hsize,
  input  logic                 hready,     // Muxed ready from the bus
  input  logic                 enable,     // From CTRL register
  input  logic                 done,       // Sequencer in HOLD
  output logic                 req,        // Start one EMI cycle
  output logic                 req_write,
  output logic [ADDR_BITS-1:0] req_addr,   // Byte address in memory
  output logic [3:0]           req_be,     // Active-high byte lanes
  output logic                 smc_hready,
  output logic [1:0]           smc_hresp,
  output logic                 smc_valid   // Address accepted last cycle
);

  logic accept;   // Address phase taken this edge
  logic legal;    // In range and controller enabled
  logic xfer_q;   // Legal data phase waiting on the sequencer
  logic err1_q;   // First ERROR cycle, hready low
  logic err2_q;   // Second ERROR cycle, hready high
  logic valid_q;

  // --------------------
  // Address phase qualification
  // --------------------

  assign accept = hsel && hready &&
                  (htrans == smc_bus_pkg::NONSEQ || htrans == smc_bus_pkg::SEQ);

  // Anything above the memory size is out of range
  assign legal = enable && ((haddr >> ADDR_BITS) == 32'd0);

  // Request goes out with the address phase so SETUP is the first data cycle
  assign req       = accept && legal;
  assign req_write = hwrite;
  assign req_addr  = haddr[ADDR_BITS-1:0];

  // Lanes from size and low address bits
  always_comb begin
    case (hsize)
      smc_bus_pkg::BYTE: begin
        req_be = smc_mem_pkg::BE_BYTE << haddr[1:0];
      end
      smc_bus_pkg::HALF: begin
        req_be = smc_mem_pkg::BE_HALF << {haddr[1], 1'b0}; // Bit 1 picks the pair
      end
      default: begin
        req_be = smc_mem_pkg::BE_WORD;                     // Word and anything wider
      end
    endcase
  end

  // --------------------
  // Data phase tracking
  // --------------------

  always_ff @(posedge hclk) begin
    if (reset) begin
      xfer_q  <= 1'b0;
      err1_q  <= 1'b0;
      err2_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= accept;                 // One pulse per accepted address
      err1_q  <= accept && !legal;       // Rejected access starts error pair
      err2_q  <= err1_q;
      if (req) begin
        xfer_q <= 1'b1;                  // New transfer wins over done in HOLD
      end else if (done) begin
        xfer_q <= 1'b0;
      end
    end
  end

  // --------------------
  // Response
  // --------------------

  // Low through SETUP and STROBE, released by done in HOLD
  assign smc_hready = !err1_q && (!xfer_q || done);

  assign smc_hresp = (err1_q || err2_q) ? smc_bus_pkg::ERROR : smc_bus_pkg::OKAY;

  assign smc_valid = valid_q;

endmodule

// File: rtl/smc_apb_regs.sv
// --------------------
// SMC APB registers
// --------------------

module smc_apb_regs #(
  parameter int WAIT_BITS = 4
) (
  input  logic                 hclk,    // Shared AHB and APB clock
  input  logic                 reset,   // Sync reset, active high
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [4:0]           paddr,   // Register offset
  input  logic [31:0]          pwdata,
  input  logic                 busy,    // Live flag from EMI sequencer
  output logic [31:0]          prdata,
  output logic                 enable,  // Controller enable to AHB slave
  output logic [WAIT_BITS-1:0] rd_wait, // Read wait states to sequencer
  output logic [WAIT_BITS-1:0] wr_wait  // Write wait states to sequencer
);

  logic wr_en;

  // No wait states, write lands in the access phase
  assign wr_en = psel && penable && pwrite;

  // --------------------
  // Register writes
  // --------------------

  always_ff @(posedge hclk) begin
    if (reset) begin
      enable  <= 1'b0;                                  // Disabled out of reset
      rd_wait <= WAIT_BITS'(smc_mem_pkg::RD_WAIT_RESET);
      wr_wait <= WAIT_BITS'(smc_mem_pkg::WR_WAIT_RESET);
    end else if (wr_en) begin
      case (paddr)
        smc_bus_pkg::REG_CTRL: begin
          enable <= pwdata[smc_bus_pkg::CTRL_EN_BIT];
        end
        smc_bus_pkg::REG_RD_WAIT: begin
          rd_wait <= pwdata[WAIT_BITS-1:0];
        end
        smc_bus_pkg::REG_WR_WAIT: begin
          wr_wait <= pwdata[WAIT_BITS-1:0];
        end
        // STATUS is read-only, unmapped offsets ignored
        default: begin
        end
      endcase
    end
  end

  // --------------------
  // Read mux
  // --------------------

  always_comb begin
    prdata = '0;                             // Unmapped reads return zero
    if (psel && !pwrite) begin
      case (paddr)
        smc_bus_pkg::REG_CTRL:    prdata[smc_bus_pkg::CTRL_EN_BIT] = enable;
        smc_bus_pkg::REG_RD_WAIT: prdata = 32'(rd_wait);
        smc_bus_pkg::REG_WR_WAIT: prdata = 32'(wr_wait);
        smc_bus_pkg::REG_STATUS:  prdata[smc_bus_pkg::STATUS_BUSY_BIT] = busy;
        default:                  prdata = '0;
      endcase
    end
  end

endmodule

// File: rtl/smc_bus_pkg.sv
// --------------------
// AHB and APB bus definitions
// --------------------

package smc_bus_pkg;

  // --------------------
  // AHB-lite encodings
  // --------------------

  // Transfer type on htrans
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // Transfer size on hsize, wider sizes unsupported
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_e;

  // Slave response, no split or retry
  typedef enum logic [1:0] {
    OKAY  = 2'b00,
    ERROR = 2'b01
  } hresp_e;

  // --------------------
  // APB register map
  // --------------------

  localparam logic [4:0] REG_CTRL    = 5'h00; // Enable control
  localparam logic [4:0] REG_RD_WAIT = 5'h04; // Read wait states
  localparam logic [4:0] REG_WR_WAIT = 5'h08; // Write wait states
  localparam logic [4:0] REG_STATUS  = 5'h0C; // Read-only status

  localparam int CTRL_EN_BIT     = 0; // Controller enable in REG_CTRL
  localparam int STATUS_BUSY_BIT = 0; // Live busy flag in REG_STATUS

endpackage

// File: rtl/smc_emi_fsm.sv
// --------------------
// SMC EMI cycle sequencer
// --------------------

module smc_emi_fsm #(
  parameter int ADDR_BITS = 16,
  parameter int WAIT_BITS = 4
) (
  input  logic                 hclk,
  input  logic                 reset,
  input  logic                 req,          // One pulse per legal transfer
  input  logic                 req_write,
  input  logic [ADDR_BITS-1:0] req_addr,
  input  logic [3:0]           req_be,       // Active-high lanes
  input  logic [31:0]          hwdata,       // Valid in SETUP
  input  logic [WAIT_BITS-1:0] rd_wait,
  input  logic [WAIT_BITS-1:0] wr_wait,
  input  logic [31:0]          data_smc,     // Read data from memory
  output logic                 done,         // High in HOLD
  output logic                 busy,         // Cycle in progress
  output logic [31:0]          smc_hrdata,   // Held until next read
  output logic [31:0]          smc_addr,
  output logic [31:0]          smc_data,
  output logic [3:0]           smc_n_be,
  output logic                 smc_n_cs,
  output logic                 smc_n_wr,
  output logic [3:0]           smc_n_we,
  output logic                 smc_n_rd,
  output logic                 smc_n_ext_oe
);

  smc_mem_pkg::emi_state_e state_q;
  smc_mem_pkg::emi_state_e state_d;

  logic [WAIT_BITS-1:0] cnt_q;    // Remaining STROBE cycles minus one
  logic                 write_q;
  logic                 write_d;
  logic [ADDR_BITS-1:0] addr_q;
  logic [3:0]           be_q;
  logic [3:0]           be_d;
  logic                 load;     // Take a new request this edge
  logic                 last_strobe;

  // New cycle from IDLE or straight out of HOLD
  assign load = req && (state_q == smc_mem_pkg::IDLE || state_q == smc_mem_pkg::HOLD);

  assign last_strobe = (state_q == smc_mem_pkg::STROBE) && (cnt_q == '0);

  // Attributes of the cycle that state_d belongs to
  assign write_d = load ? req_write : write_q;
  assign be_d    = load ? req_be : be_q;

  // --------------------
  // Next state
  // --------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      smc_mem_pkg::IDLE: begin
        if (req) begin
          state_d = smc_mem_pkg::SETUP;
        end
      end
      smc_mem_pkg::SETUP: begin
        state_d = smc_mem_pkg::STROBE;
      end
      smc_mem_pkg::STROBE: begin
        if (cnt_q == '0) begin
          state_d = smc_mem_pkg::HOLD;
        end
      end
      smc_mem_pkg::HOLD: begin
        state_d = req ? smc_mem_pkg::SETUP : smc_mem_pkg::IDLE; // Back-to-back
      end
      default: begin
        state_d = smc_mem_pkg::IDLE;
      end
    endcase
  end

  // --------------------
  // Control and strobes
  // --------------------

  // Pins decoded from next state so they change cleanly on the edge
  always_ff @(posedge hclk) begin
    if (reset) begin
      state_q      <= smc_mem_pkg::IDLE;
      cnt_q        <= '0;
      write_q      <= 1'b0;
      done         <= 1'b0;
      busy         <= 1'b0;
      smc_n_cs     <= 1'b1;
      smc_n_rd     <= 1'b1;
      smc_n_we     <= smc_mem_pkg::BE_NONE;
      smc_n_wr     <= 1'b1;
      smc_n_ext_oe <= 1'b1;
      smc_n_be     <= smc_mem_pkg::BE_NONE;
    end else begin
      state_q <= state_d;
      write_q <= write_d;
      if (load) begin
        cnt_q <= req_write ? wr_wait : rd_wait;      // STROBE runs W+1 cycles
      end else if (state_q == smc_mem_pkg::STROBE && cnt_q != '0) begin
        cnt_q <= cnt_q - WAIT_BITS'(1);
      end
      done         <= (state_d == smc_mem_pkg::HOLD);
      busy         <= (state_d != smc_mem_pkg::IDLE);
      smc_n_cs     <= (state_d == smc_mem_pkg::IDLE);
      smc_n_rd     <= !((state_d == smc_mem_pkg::STROBE) && !write_d);
      smc_n_we     <= ((state_d == smc_mem_pkg::STROBE) && write_d) ? ~be_d
                                                                    : smc_mem_pkg::BE_NONE;
      smc_n_wr     <= !((state_d != smc_mem_pkg::IDLE) && write_d);
      smc_n_ext_oe <= !((state_d != smc_mem_pkg::IDLE) && write_d); // Drive data bus
      smc_n_be     <= (state_d != smc_mem_pkg::IDLE) ? ~be_d : smc_mem_pkg::BE_NONE;
    end
  end

  // --------------------
  // Address and data
  // --------------------

  always_ff @(posedge hclk) begin
    if (load) begin
      addr_q <= req_addr;
      be_q   <= req_be;
    end
    if (state_q == smc_mem_pkg::SETUP) begin
      smc_data <= hwdata;                 // First data-phase cycle
    end
    if (last_strobe && !write_q) begin
      smc_hrdata <= data_smc;             // Sampled before n_rd rises
    end
  end

  // Word aligned, lanes carried by the byte enables
  assign smc_addr = 32'({addr_q[ADDR_BITS-1:2], 2'b00});

endmodule

// File: rtl/smc_mem_pkg.sv
// --------------------
// EMI cycle definitions
// --------------------

package smc_mem_pkg;

  // --------------------
  // EMI sequencer states
  // --------------------

  // One memory cycle walks SETUP, STROBE, HOLD
  typedef enum logic [1:0] {
    IDLE   = 2'b00, // No cycle, chip select high
    SETUP  = 2'b01, // Address and enables out, write data latched
    STROBE = 2'b10, // Read or write strobe low for wait states plus one
    HOLD   = 2'b11  // Strobes released, AHB data phase completes
  } emi_state_e;

  // --------------------
  // Timing register reset values
  // --------------------

  // Sized to the wait-state count width where they are used
  localparam int unsigned RD_WAIT_RESET = 2;
  localparam int unsigned WR_WAIT_RESET = 2;

  // --------------------
  // Byte-enable helpers
  // --------------------

  // Active-low idle value for smc_n_be and smc_n_we
  localparam logic [3:0] BE_NONE = 4'b1111;

  // Active-high lane patterns before the address shift
  localparam logic [3:0] BE_BYTE = 4'b0001; // Single lane
  localparam logic [3:0] BE_HALF = 4'b0011; // Lane pair
  localparam logic [3:0] BE_WORD = 4'b1111; // All four lanes

endpackage

// File: rtl/smc_top.sv
// --------------------
// Static memory controller top
// --------------------

module smc_top #(
  parameter int ADDR_BITS = 16, // Memory is 2^ADDR_BITS bytes
  parameter int WAIT_BITS = 4   // Width of wait-state counts
) (
  input  logic        hclk,         // AHB clock, APB runs on it too
  input  logic        reset,        // Sync reset, active high
  // APB
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [4:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  // AHB-lite
  input  logic        hsel,
  input  logic [31:0] haddr,
  input  logic [1:0]  htrans,
  input  logic        hwrite,
  input  logic [2:0]  hsize,
  input  logic [31:0] hwdata,
  input  logic        hready,       // Muxed ready
  output logic [31:0] smc_hrdata,
  output logic        smc_hready,
  output logic        smc_valid,
  output logic [1:0]  smc_hresp,
  // EMI
  input  logic [31:0] data_smc,     // Read data from memory
  output logic [31:0] smc_addr,
  output logic [31:0] smc_data,     // Write data to memory
  output logic [3:0]  smc_n_be,
  output logic        smc_n_cs,
  output logic        smc_n_wr,
  output logic [3:0]  smc_n_we,
  output logic        smc_n_rd,
  output logic        smc_n_ext_oe,
  output logic        smc_busy
);

  logic                 enable;
  logic [WAIT_BITS-1:0] rd_wait;
  logic [WAIT_BITS-1:0] wr_wait;
  logic                 req;
  logic                 req_write;
  logic [ADDR_BITS-1:0] req_addr;
  logic [3:0]           req_be;
  logic                 done;

  // --------------------
  // Configuration
  // --------------------

  smc_apb_regs #(
    .WAIT_BITS (WAIT_BITS)
  ) i_smc_apb_regs (
    .hclk    (hclk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .busy    (smc_busy),   // Status reads the live flag
    .prdata  (prdata),
    .enable  (enable),
    .rd_wait (rd_wait),
    .wr_wait (wr_wait)
  );

  // --------------------
  // Bus side
  // --------------------

  smc_ahb_slave #(
    .ADDR_BITS (ADDR_BITS)
  ) i_smc_ahb_slave (
    .hclk       (hclk),
    .reset      (reset),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .hsize      (hsize),
    .hready     (hready),
    .enable     (enable),
    .done       (done),
    .req        (req),
    .req_write  (req_write),
    .req_addr   (req_addr),
    .req_be     (req_be),
    .smc_hready (smc_hready),
    .smc_hresp  (smc_hresp),
    .smc_valid  (smc_valid)
  );

  // --------------------
  // Memory side
  // --------------------

  smc_emi_fsm #(
    .ADDR_BITS (ADDR_BITS),
    .WAIT_BITS (WAIT_BITS)
  ) i_smc_emi_fsm (
    .hclk         (hclk),
    .reset        (reset),
    .req          (req),
    .req_write    (req_write),
    .req_addr     (req_addr),
    .req_be       (req_be),
    .hwdata       (hwdata),      // Straight from the bus, latched in SETUP
    .rd_wait      (rd_wait),
    .wr_wait      (wr_wait),
    .data_smc     (data_smc),
    .done         (done),
    .busy         (smc_busy),
    .smc_hrdata   (smc_hrdata),
    .smc_addr     (smc_addr),
    .smc_data     (smc_data),
    .smc_n_be     (smc_n_be),
    .smc_n_cs     (smc_n_cs),
    .smc_n_wr     (smc_n_wr),
    .smc_n_we     (smc_n_we),
    .smc_n_rd     (smc_n_rd),
    .smc_n_ext_oe (smc_n_ext_oe)
  );

endmodule

// File: tb/smc_assert.sv
// --------------------
// SMC bound assertions
// --------------------

module smc_assert (
  input logic       hclk,
  input logic       reset,
  input logic       smc_n_rd,
  input logic [3:0] smc_n_we,
  input logic       smc_n_cs,
  input logic       smc_busy,
  input logic       smc_hready,
  input logic [1:0] smc_hresp
);

  int fail_count = 0; // Failed assertions, summed into the testbench error count

  // Strobes never overlap
  a_rd_we_excl: assert property (@(posedge hclk) disable iff (reset)
    !(!smc_n_rd && smc_n_we != 4'hF))
    else begin
      fail_count++;
      $error("read and write strobes active together");
    end

  a_cs_busy: assert property (@(posedge hclk) disable iff (reset)
    !smc_n_cs |-> smc_busy)
    else begin
      fail_count++;
      $error("chip select low while not busy");
    end

  // Two-cycle ERROR response
  a_err_seq: assert property (@(posedge hclk) disable iff (reset)
    (smc_hresp == smc_bus_pkg::ERROR && !smc_hready) |=>
    (smc_hresp == smc_bus_pkg::ERROR && smc_hready))
    else begin
      fail_count++;
      $error("ERROR response not completed in its second cycle");
    end

  a_err_no_cs: assert property (@(posedge hclk) disable iff (reset)
    smc_hresp == smc_bus_pkg::ERROR |-> smc_n_cs)
    else begin
      fail_count++;
      $error("chip select low during ERROR response");
    end

endmodule

bind smc_top smc_assert i_smc_assert (.*);

// File: tb/smc_sram_model.sv
// --------------------
// Byte-lane SRAM model
// --------------------

module smc_sram_model #(
  parameter int ADDR_BITS = 16
) (
  input  logic [31:0] smc_addr,
  input  logic [31:0] smc_data,
  input  logic [3:0]  smc_n_we,  // Per-lane write strobes, active low
  input  logic        smc_n_rd,
  output logic [31:0] data_smc
);

  logic [7:0]           mem [0:2**ADDR_BITS-1];
  logic [ADDR_BITS-3:0] word;
  logic [3:0]           we_prev = 4'hF;

  assign word = smc_addr[ADDR_BITS-1:2];

  // Fill pattern folds every address bit
  initial begin
    int i;
    for (i = 0; i < 2**ADDR_BITS; i++) begin
      mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
    end
  end

  // Lane written on the rising edge of its strobe
  always @(smc_n_we) begin
    int k;
    for (k = 0; k < 4; k++) begin
      if (!we_prev[k] && smc_n_we[k]) begin
        mem[{word, 2'(k)}] = smc_data[8*k +: 8];
      end
    end
    we_prev = smc_n_we;
  end

  assign data_smc = smc_n_rd ? 32'h0 :  // Bus idle outside read strobe
                    {mem[{word, 2'd3}], mem[{word, 2'd2}], mem[{word, 2'd1}], mem[{word, 2'd0}]};

endmodule

// File: tb/smc_tb.sv
// --------------------
// SMC testbench
// --------------------

module smc_tb;

  localparam int ADDR_BITS   = 16;
  localparam int WAIT_BITS   = 4;
  localparam int PERIOD      = 4;
  localparam int MAX_OPS     = 64;
  localparam int TEST_CYCLES = 60 + 120 + 150 + 120 + 500 + 60; // Per test, in run order

  logic        hclk;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [4:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        hsel;
  logic [31:0] haddr;
  logic [1:0]  htrans;
  logic        hwrite;
  logic [2:0]  hsize;
  logic [31:0] hwdata;
  logic        hready;
  logic        bp_hold;       // Forces muxed hready low
  logic [31:0] smc_hrdata;
  logic        smc_hready;
  logic        smc_valid;
  logic [1:0]  smc_hresp;
  logic [31:0] data_smc;
  logic [31:0] smc_addr;
  logic [31:0] smc_data;
  logic [3:0]  smc_n_be;
  logic        smc_n_cs;
  logic        smc_n_wr;
  logic [3:0]  smc_n_we;
  logic        smc_n_rd;
  logic        smc_n_ext_oe;
  logic        smc_busy;

  int          err_count;
  int          check_count;
  int          seed;
  int          cs_low_cycles;
  int          cur_rd_wait;
  int          cur_wr_wait;
  int          n_ops;
  logic        op_wr      [MAX_OPS];
  logic [31:0] op_addr    [MAX_OPS];
  logic [2:0]  op_size    [MAX_OPS];
  logic [31:0] op_wdata   [MAX_OPS];
  logic        op_bad     [MAX_OPS]; // ERROR response expected
  logic [31:0] exp_rdata  [MAX_OPS];
  logic [3:0]  exp_mask   [MAX_OPS];
  logic [31:0] res_rdata  [MAX_OPS];
  int          res_cycles [MAX_OPS];
  int          res_errs   [MAX_OPS];
  logic        res_valid  [MAX_OPS];
  logic [31:0] sb_word    [0:2**(ADDR_BITS-2)-1]; // Scoreboard, one entry per word

  // Single slave, bus mux reduces to its own ready
  assign hready = bp_hold ? 1'b0 : smc_hready;

  smc_top #(
    .ADDR_BITS (ADDR_BITS),
    .WAIT_BITS (WAIT_BITS)
  ) i_smc_top (.*);

  smc_sram_model #(.ADDR_BITS(ADDR_BITS)) i_smc_sram_model (.*);

  always #(PERIOD / 2) hclk = ~hclk;

  always @(negedge hclk) begin
    if (!smc_n_cs) cs_low_cycles++;  // Mid-cycle sample
  end

  // --------------------
  // Helpers
  // --------------------

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Fail at time %0t: %s (got 0x%0h, expected 0x%0h)", $time, msg, got, exp);
    end
  endtask

  function automatic logic [3:0] lane_mask(input logic [2:0] size, input logic [1:0] off);
    case (size)
      3'd0:    return 4'b0001 << off;
      3'd1:    return off[1] ? 4'b1100 : 4'b0011;  // Pair picked by bit 1
      default: return 4'b1111;
    endcase
  endfunction

  function automatic logic [31:0] lane_bits(input logic [3:0] m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
  endfunction

  task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
    psel    = 1'b1;
    pwrite  = 1'b1;
    penable = 1'b0;
    paddr   = addr;
    pwdata  = data;
    @(posedge hclk);
    #1;
    penable = 1'b1;                  // Access phase, write lands on next edge
    @(posedge hclk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
    psel    = 1'b1;
    pwrite  = 1'b0;
    penable = 1'b0;
    paddr   = addr;
    @(posedge hclk);
    #1;
    penable = 1'b1;
    #1;
    data = prdata;                   // Combinational read, settled
    @(posedge hclk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic set_waits(input int rd, input int wr);
    apb_write(smc_bus_pkg::REG_RD_WAIT, rd);
    apb_write(smc_bus_pkg::REG_WR_WAIT, wr);
    cur_rd_wait = rd;
    cur_wr_wait = wr;
  endtask

  task automatic clear_ops();
    n_ops = 0;
  endtask

  // Queue one transfer and update the scoreboard in issue order
  task automatic add_op(input logic wr, input logic [31:0] addr, input logic [2:0] size,
                        input logic [31:0] wdata, input logic bad);
    logic [3:0]           mask;
    logic [ADDR_BITS-3:0] widx;
    mask = lane_mask(size, addr[1:0]);
    widx = addr[ADDR_BITS-1:2];
    op_wr[n_ops]     = wr;
    op_addr[n_ops]   = addr;
    op_size[n_ops]   = size;
    op_wdata[n_ops]  = wdata;
    op_bad[n_ops]    = bad;
    exp_mask[n_ops]  = mask;
    exp_rdata[n_ops] = sb_word[widx];
    if (wr && !bad) begin
      for (int k = 0; k < 4; k++) begin
        if (mask[k]) sb_word[widx][8*k +: 8] = wdata[8*k +: 8];
      end
    end
    n_ops++;
  endtask

  task automatic drive_addr(input int i);
    if (i < n_ops) begin
      hsel   = 1'b1;
      htrans = smc_bus_pkg::NONSEQ;
      haddr  = op_addr[i];
      hwrite = op_wr[i];
      hsize  = op_size[i];
    end else begin
      hsel   = 1'b0;
      htrans = smc_bus_pkg::IDLE;
    end
  endtask

  // Chip select, lanes, write select and address held from SETUP through HOLD
  task automatic verify_emi_pins(input int i);
    check_eq({smc_n_cs, smc_n_wr, smc_n_ext_oe, smc_n_be},
             {1'b0, !op_wr[i], !op_wr[i], ~exp_mask[i]},
             $sformatf("EMI control pins for op at 0x%0h", op_addr[i]));
    check_eq(smc_addr, op_addr[i] & 32'(2**ADDR_BITS - 4),
             $sformatf("EMI address for op at 0x%0h", op_addr[i]));
  endtask

  // Pipelined master, next address overlaps the current data phase
  task automatic run_ops();
    int   a;
    int   d;
    int   cyc;
    int   errs;
    logic ready;
    a    = 0;
    d    = -1;
    cyc  = 0;
    errs = 0;
    drive_addr(0);
    while (a < n_ops || d >= 0) begin
      ready = smc_hready;              // What the coming edge samples
      if (d >= 0) begin
        cyc++;
        if (smc_hresp == smc_bus_pkg::ERROR) errs++;
        if (!op_bad[d]) begin
          verify_emi_pins(d);
        end
        if (ready) begin
          res_rdata[d]  = smc_hrdata;
          res_cycles[d] = cyc;
          res_errs[d]   = errs;
          d = -1;
        end
      end
      @(posedge hclk);
      #1;
      if (ready && a < n_ops) begin    // Address accepted at that edge
        d            = a;
        cyc          = 0;
        errs         = 0;
        res_valid[d] = smc_valid;
        hwdata       = op_wdata[a];
        a++;
        drive_addr(a);
      end
    end
  endtask

  task automatic check_ops(input string tag);
    int          i;
    int          w;
    logic [31:0] m;
    for (i = 0; i < n_ops; i++) begin
      w = op_wr[i] ? cur_wr_wait : cur_rd_wait;
      m = lane_bits(exp_mask[i]);
      check_eq(res_valid[i], 1'b1, $sformatf("%s op %0d valid pulse", tag, i));
      if (op_bad[i]) begin
        check_eq(res_cycles[i], 2, $sformatf("%s op %0d error length", tag, i));
        check_eq(res_errs[i], 2, $sformatf("%s op %0d ERROR cycles", tag, i));
      end else begin
        check_eq(res_cycles[i], w + 3, $sformatf("%s op %0d data phase length", tag, i));
        check_eq(res_errs[i], 0, $sformatf("%s op %0d response", tag, i));
        if (!op_wr[i]) begin
          check_eq(res_rdata[i] & m, exp_rdata[i] & m, $sformatf("%s op %0d rdata", tag, i));
        end
      end
    end
  endtask

  task automatic report_test(input string name, input int start);
    $display("%-16s done, %0d errors", name, err_count - start);
  endtask

  // --------------------
  // Tests
  // --------------------

  task automatic reset_and_regs();
    int          start;
    logic [31:0] rd;
    start = err_count;
    check_eq(smc_hready, 1'b1, "hready after reset");
    check_eq(smc_hresp, 2'b00, "hresp after reset");
    check_eq(smc_n_cs, 1'b1, "n_cs after reset");
    check_eq(smc_n_be, 4'hF, "n_be after reset");
    check_eq(smc_busy, 1'b0, "busy after reset");
    check_eq(smc_valid, 1'b0, "valid after reset");
    apb_read(smc_bus_pkg::REG_CTRL, rd);
    check_eq(rd, 0, "CTRL reset value");
    apb_read(smc_bus_pkg::REG_RD_WAIT, rd);
    check_eq(rd, 2, "RD_WAIT reset value");
    apb_read(smc_bus_pkg::REG_WR_WAIT, rd);
    check_eq(rd, 2, "WR_WAIT reset value");
    apb_write(smc_bus_pkg::REG_RD_WAIT, 7);
    apb_read(smc_bus_pkg::REG_RD_WAIT, rd);
    check_eq(rd, 7, "RD_WAIT readback");
    apb_write(smc_bus_pkg::REG_WR_WAIT, 9);
    apb_read(smc_bus_pkg::REG_WR_WAIT, rd);
    check_eq(rd, 9, "WR_WAIT readback");
    apb_write(smc_bus_pkg::REG_CTRL, 1);
    apb_read(smc_bus_pkg::REG_CTRL, rd);
    check_eq(rd, 1, "CTRL readback");
    apb_write(smc_bus_pkg::REG_STATUS, 32'hFFFF_FFFF);  // Read-only
    apb_read(smc_bus_pkg::REG_STATUS, rd);
    check_eq(rd, 0, "STATUS idle");
    apb_read(5'h10, rd);
    check_eq(rd, 0, "unmapped offset");
    report_test("reset_and_regs", start);
  endtask

  task automatic word_access();
    int start;
    int k;
    int w;
    start = err_count;
    for (k = 0; k < 3; k++) begin
      w = (k == 0) ? 0 : (k == 1) ? 2 : 5;
      set_waits(w, w);
      clear_ops();
      add_op(1'b1, 32'h100 + 4 * k, smc_bus_pkg::WORD, $random(seed), 1'b0);
      add_op(1'b0, 32'h100 + 4 * k, smc_bus_pkg::WORD, 0, 1'b0);
      run_ops();
      check_ops($sformatf("word W=%0d", w));
    end
    report_test("word_access", start);
  endtask

  task automatic subword_access();
    int start;
    int off;
    start = err_count;
    set_waits(2, 1);
    clear_ops();
    add_op(1'b1, 32'h300, smc_bus_pkg::WORD, $random(seed), 1'b0);
    for (off = 0; off < 4; off++) begin
      add_op(1'b1, 32'h300 + off, smc_bus_pkg::BYTE, $random(seed), 1'b0);
      add_op(1'b0, 32'h300, smc_bus_pkg::WORD, 0, 1'b0);
    end
    for (off = 0; off < 4; off += 2) begin
      add_op(1'b1, 32'h300 + off, smc_bus_pkg::HALF, $random(seed), 1'b0);
      add_op(1'b0, 32'h300, smc_bus_pkg::WORD, 0, 1'b0);
    end
    run_ops();
    check_ops("subword");
    report_test("subword_access", start);
  endtask

  task automatic error_response();
    int start;
    int cs_before;
    start = err_count;
    set_waits(1, 1);
    clear_ops();
    add_op(1'b1, 32'h40, smc_bus_pkg::WORD, $random(seed), 1'b0);
    run_ops();
    check_ops("error setup");
    cs_before = cs_low_cycles;
    clear_ops();
    add_op(1'b1, 32'h0001_0040, smc_bus_pkg::WORD, $random(seed), 1'b1); // Aliases 0x40
    add_op(1'b0, 32'h0001_0040, smc_bus_pkg::WORD, 0, 1'b1);
    add_op(1'b0, 32'hFFFF_FFFC, smc_bus_pkg::WORD, 0, 1'b1);
    run_ops();
    check_ops("out of range");
    apb_write(smc_bus_pkg::REG_CTRL, 0);
    clear_ops();
    add_op(1'b1, 32'h40, smc_bus_pkg::WORD, $random(seed), 1'b1);
    add_op(1'b0, 32'h40, smc_bus_pkg::HALF, 0, 1'b1);
    run_ops();
    check_ops("disabled");
    check_eq(cs_low_cycles, cs_before, "chip select during errors");
    apb_write(smc_bus_pkg::REG_CTRL, 1);
    clear_ops();
    add_op(1'b0, 32'h40, smc_bus_pkg::WORD, 0, 1'b0);  // Contents unchanged
    run_ops();
    check_ops("after errors");
    report_test("error_response", start);
  endtask

  task automatic random_stream();
    int          start;
    int          i;
    int          sz;
    logic        wr;
    logic [31:0] addr;
    start = err_count;
    set_waits(1, 3);
    clear_ops();
    for (i = 0; i < 16; i++) begin     // Prefill the region
      add_op(1'b1, 32'h200 + 4 * i, smc_bus_pkg::WORD, $random(seed), 1'b0);
    end
    for (i = 0; i < 40; i++) begin
      wr   = 1'($random(seed));
      sz   = $unsigned($random(seed)) % 3;
      addr = 32'h200 + 4 * ($unsigned($random(seed)) % 16);
      if (sz == 0) addr[1:0] = 2'($random(seed));
      else if (sz == 1) addr[1] = 1'($random(seed));
      add_op(wr, addr, 3'(sz), $random(seed), 1'b0);
    end
    run_ops();
    check_ops("random");
    report_test("random_stream", start);
  endtask

  task automatic back_pressure();
    int start;
    int k;
    start = err_count;
    clear_ops();
    add_op(1'b0, 32'h40, smc_bus_pkg::WORD, 0, 1'b0);
    bp_hold = 1'b1;
    drive_addr(0);
    for (k = 0; k < 5; k++) begin
      @(posedge hclk);
      #1;
      check_eq(smc_valid, 1'b0, "valid under back-pressure");
      check_eq(smc_n_cs, 1'b1, "n_cs under back-pressure");
    end
    bp_hold = 1'b0;
    run_ops();
    check_ops("back-pressure");
    report_test("back_pressure", start);
  endtask

  // --------------------
  // Main sequence and watchdog
  // --------------------

  initial begin
    hclk          = 1'b0;
    reset         = 1'b1;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    hsel          = 1'b0;
    haddr         = '0;
    htrans        = smc_bus_pkg::IDLE;
    hwrite        = 1'b0;
    hsize         = smc_bus_pkg::WORD;
    hwdata        = '0;
    bp_hold       = 1'b0;
    err_count     = 0;
    check_count   = 0;
    cs_low_cycles = 0;
    n_ops         = 0;
    seed          = 42;
    repeat (3) @(posedge hclk);
    #1;
    reset = 1'b0;
    reset_and_regs();
    word_access();
    subword_access();
    error_response();
    random_stream();
    back_pressure();
    err_count += i_smc_top.i_smc_assert.fail_count;  // Assertion failures count too
    $display("Checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(TEST_CYCLES * 2 * PERIOD);
    $display("Run timed out after %0d cycles", TEST_CYCLES * 2);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule
